// ==== rtl/posit_fmt_pkg.sv ====
package posit_fmt_pkg;

    // ========================================================================
    // Format constants, posit<16,1>
    // ========================================================================

    localparam int N  = 16;
    localparam int ES = 1;

    // Largest regime is N-2, so |te| <= (N-2) * 2^ES
    localparam int TE_MAX  = (N - 2) << ES;
    localparam int TE_SIZE = 7;                     // signed, holds +-TE_MAX plus headroom

    localparam int MANT_SIZE = N - ES - 2;          // hidden one + 12 fraction bits

    localparam int MAX_TE_DIFF = (2 ** (TE_SIZE - 1) - 1 > TE_MAX) ?
                                 TE_MAX : 2 ** (TE_SIZE - 1) - 1;

    localparam int MANT_ADD_RESULT_SIZE = MANT_SIZE + MAX_TE_DIFF + 1;
    localparam int MANT_SUB_RESULT_SIZE = MANT_ADD_RESULT_SIZE - 1;

    // Encoder work vector: exponent, fraction below the hidden one, regime room
    localparam int ENC_SIZE = N + ES + MANT_SUB_RESULT_SIZE - 1;

    typedef logic [N-1:0] posit_t;

    localparam posit_t NAR = {1'b1, {(N-1){1'b0}}};

    // ========================================================================
    // Decoded operands and core result
    // ========================================================================

    typedef struct packed {
        logic                      sign;
        logic signed [TE_SIZE-1:0] te;
        logic [MANT_SIZE-1:0]      mant;          // hidden one at MSB
    } dec_operand_t;

    typedef struct packed {
        dec_operand_t op1;                        // larger magnitude
        dec_operand_t op2;
        logic         have_opposite_sign;
        logic         is_zero_small;
        logic         result_nar;
        logic         result_zero_forced;
    } dec_pair_t;

    typedef struct packed {
        logic                            sign;
        logic signed [TE_SIZE-1:0]       te;
        logic [MANT_ADD_RESULT_SIZE-1:0] mant;    // leading one at bit MANT_SUB_RESULT_SIZE-1
        logic                            sticky;
        logic                            result_nar;
        logic                            result_zero;
    } core_result_t;

endpackage

// ==== rtl/posit_io_pkg.sv ====
package posit_io_pkg;

    // ========================================================================
    // External handshake payloads
    // ========================================================================

    // Request: a + b, or a - b when sub is set
    typedef struct packed {
        posit_fmt_pkg::posit_t a;
        posit_fmt_pkg::posit_t b;
        logic                  sub;
    } add_req_t;

    typedef struct packed {
        posit_fmt_pkg::posit_t result;
    } add_rsp_t;

endpackage

// ==== rtl/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t data_q;

    // Empty, or the current entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_data = data_q;

    // Stalled entry must stay put until taken
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== rtl/posit_decode.sv ====
`timescale 1ns/1ps

module posit_decode (
    input  posit_io_pkg::add_req_t   req,
    output posit_fmt_pkg::dec_pair_t pair
);

    import posit_fmt_pkg::*;

    function automatic posit_t magnitude(input posit_t p);
        return p[N-1] ? posit_t'(-p) : p;
    endfunction

    function automatic dec_operand_t decode_one(input posit_t p);
        posit_t                    mag;
        logic [N-2:0]              body;
        logic [N-2:0]              rest;
        logic [TE_SIZE-1:0]        run;
        logic signed [TE_SIZE-1:0] k;
        logic                      done;
        dec_operand_t              d;
        mag  = magnitude(p);
        body = mag[N-2:0];
        run  = '0;
        done = 1'b0;
        for (int i = N - 2; i >= 0; i--) begin
            if (done || body[i] != body[N-2]) begin
                done = 1'b1;
            end else begin
                run = run + 1'b1;
            end
        end
        k    = body[N-2] ? run - 1'b1 : -run;
        rest = body << (run + 1'b1);           // drop regime and terminator
        d.sign = p[N-1];
        d.te   = {k[TE_SIZE-1-ES:0], rest[N-2 -: ES]};
        d.mant = {1'b1, rest[N-2-ES -: MANT_SIZE-1]};
        return d;
    endfunction

    posit_t       b_eff;
    posit_t       mag_a;
    posit_t       mag_b;
    dec_operand_t dec_a;
    dec_operand_t dec_b;
    logic         zero_a;
    logic         zero_b;
    logic         opposite;
    logic         swap;

    assign b_eff = req.sub ? posit_t'(-req.b) : req.b;     // NaR and zero map to themselves

    assign mag_a = magnitude(req.a);
    assign mag_b = magnitude(b_eff);
    assign dec_a = decode_one(req.a);
    assign dec_b = decode_one(b_eff);

    assign zero_a   = (req.a == '0);
    assign zero_b   = (b_eff == '0);
    assign opposite = req.a[N-1] ^ b_eff[N-1];
    assign swap     = mag_b > mag_a;

    always_comb begin
        pair.op1                = swap ? dec_b : dec_a;
        pair.op2                = swap ? dec_a : dec_b;
        pair.have_opposite_sign = opposite;
        pair.is_zero_small      = zero_a || zero_b;
        pair.result_nar         = (req.a == NAR) || (b_eff == NAR);
        // Both zero, or exact cancellation
        pair.result_zero_forced = (zero_a && zero_b) || (opposite && mag_a == mag_b);
    end

endmodule

// ==== rtl/core_add.sv ====
`timescale 1ns/1ps

module core_add (
    input  logic [posit_fmt_pkg::MANT_ADD_RESULT_SIZE-1:0] mant,
    input  logic [posit_fmt_pkg::TE_SIZE-1:0]              te_diff,
    output logic [posit_fmt_pkg::MANT_ADD_RESULT_SIZE-1:0] new_mant,
    output logic [posit_fmt_pkg::TE_SIZE-1:0]              new_te_diff
);

    import posit_fmt_pkg::*;

    logic carry;

    // Same-sign sum grows by at most one bit
    assign carry = mant[MANT_ADD_RESULT_SIZE-1];

    assign new_mant    = carry ? mant >> 1 : mant;
    assign new_te_diff = te_diff + TE_SIZE'(carry);

endmodule

// ==== rtl/core_sub.sv ====
`timescale 1ns/1ps

module core_sub (
    input  logic [posit_fmt_pkg::MANT_SUB_RESULT_SIZE-1:0] mant,
    input  logic [posit_fmt_pkg::TE_SIZE-1:0]              te_diff,
    output logic [posit_fmt_pkg::MANT_SUB_RESULT_SIZE-1:0] new_mant,
    output logic [posit_fmt_pkg::TE_SIZE-1:0]              new_te_diff
);

    import posit_fmt_pkg::*;

    logic [TE_SIZE-1:0] lzc;

    // Leading-zero count, highest set bit wins
    always_comb begin
        lzc = TE_SIZE'(MANT_SUB_RESULT_SIZE);
        for (int i = 0; i < MANT_SUB_RESULT_SIZE; i++) begin
            if (mant[i]) begin
                lzc = TE_SIZE'(MANT_SUB_RESULT_SIZE - 1 - i);
            end
        end
    end

    // Cancellation can drop the leading one far down
    assign new_mant    = mant << lzc;
    assign new_te_diff = te_diff - lzc;

endmodule

// ==== rtl/core_add_sub.sv ====
`timescale 1ns/1ps

module core_add_sub (
    input  posit_fmt_pkg::dec_pair_t    pair,
    output posit_fmt_pkg::core_result_t res
);

    import posit_fmt_pkg::*;

    function automatic logic [MANT_SIZE+MAX_TE_DIFF-1:0] c2(
        input logic [MANT_SIZE+MAX_TE_DIFF-1:0] a
    );
        return ~a + 1'b1;
    endfunction

    logic signed [TE_SIZE-1:0]        te_diff;
    logic                             far;
    logic [MANT_SIZE+MAX_TE_DIFF-1:0] mant1_up;
    logic [MANT_SIZE+MAX_TE_DIFF-1:0] mant2_up;
    logic [MANT_ADD_RESULT_SIZE-1:0]  mant_sum;
    logic                             carry_lost;

    logic [MANT_ADD_RESULT_SIZE-1:0]  add_mant;
    logic [TE_SIZE-1:0]               add_te_diff;
    logic [MANT_SUB_RESULT_SIZE-1:0]  sub_mant;
    logic [TE_SIZE-1:0]               sub_te_diff;
    logic [TE_SIZE-1:0]               te_diff_upd;
    logic [MANT_ADD_RESULT_SIZE-1:0]  norm_mant;

    // ========================================================================
    // Alignment
    // ========================================================================

    assign te_diff = pair.op1.te - pair.op2.te;
    assign far     = te_diff > MAX_TE_DIFF;        // op2 lies wholly below the window

    assign mant1_up = {pair.op1.mant, {MAX_TE_DIFF{1'b0}}};
    // One LSB stands in for a far operand, so its side of op1 is kept
    assign mant2_up = far ? (MANT_SIZE+MAX_TE_DIFF)'(1)
                          : {pair.op2.mant, {MAX_TE_DIFF{1'b0}}} >> te_diff;

    assign mant_sum = {1'b0, mant1_up}
        + {1'b0, pair.have_opposite_sign ? c2(mant2_up) : mant2_up};

    // core_add drops bit 0 on a carry
    assign carry_lost = !pair.have_opposite_sign && mant_sum[MANT_ADD_RESULT_SIZE-1]
        && mant_sum[0];

    // ========================================================================
    // Normalization
    // ========================================================================

    core_add core_add_inst (
        .mant        (mant_sum),
        .te_diff     (te_diff),
        .new_mant    (add_mant),
        .new_te_diff (add_te_diff)
    );

    core_sub core_sub_inst (
        .mant        (mant_sum[MANT_SUB_RESULT_SIZE-1:0]),
        .te_diff     (te_diff),
        .new_mant    (sub_mant),
        .new_te_diff (sub_te_diff)
    );

    assign te_diff_upd = pair.have_opposite_sign ? sub_te_diff : add_te_diff;
    assign norm_mant   = pair.have_opposite_sign ? {1'b0, sub_mant} : add_mant;

    always_comb begin
        res.sign        = pair.op1.sign;
        res.result_nar  = pair.result_nar;
        res.result_zero = pair.result_zero_forced;
        if (pair.is_zero_small) begin
            res.te     = pair.op1.te;                  // other operand unchanged
            res.mant   = {1'b0, pair.op1.mant, {MAX_TE_DIFF{1'b0}}};
            res.sticky = 1'b0;
        end else begin
            res.te     = pair.op2.te + te_diff_upd;
            res.mant   = norm_mant;
            res.sticky = far || carry_lost;
        end
    end

    // Decoder puts the larger magnitude first
    te_order: assert final ($isunknown(pair) || pair.result_nar || te_diff >= 0);

endmodule

// ==== rtl/posit_round_encode.sv ====
`timescale 1ns/1ps

module posit_round_encode (
    input  posit_fmt_pkg::core_result_t res,
    output posit_io_pkg::add_rsp_t      rsp
);

    import posit_fmt_pkg::*;

    logic signed [TE_SIZE-1:0] k;
    logic [TE_SIZE-1:0]        rlen;
    logic [ENC_SIZE-1:0]       regime;
    logic [ENC_SIZE-1:0]       tail;
    logic [ENC_SIZE-1:0]       body;
    logic [N-2:0]              mag;
    logic [N-2:0]              mag_rnd;
    logic [N-2:0]              mag_sel;
    logic                      guard;
    logic                      sticky;
    logic                      round_up;
    posit_t                    word;

    // ========================================================================
    // Field packing and rounding
    // ========================================================================

    always_comb begin
        k = res.te >>> ES;
        if (k >= 0) begin
            regime = ~({ENC_SIZE{1'b1}} >> (k + 1));    // k+1 ones, then a zero
            rlen   = k + 2;
        end else begin
            regime = {1'b1, {(ENC_SIZE-1){1'b0}}} >> (-k);
            rlen   = 1 - k;
        end

        tail = {res.te[ES-1:0], res.mant[MANT_SUB_RESULT_SIZE-2:0], {N{1'b0}}};
        body = regime | (tail >> rlen);

        mag      = body[ENC_SIZE-1 -: N-1];
        guard    = body[ENC_SIZE-N];
        sticky   = |body[ENC_SIZE-N-1:0] || res.sticky;
        round_up = guard && (sticky || mag[0]);      // nearest, ties to even
        mag_rnd  = mag + round_up;
    end

    // ========================================================================
    // Saturation and sign
    // ========================================================================

    always_comb begin
        if (res.te > TE_MAX) begin
            mag_sel = '1;                               // maxpos
        end else if (res.te < -TE_MAX) begin
            mag_sel = (N-1)'(1);                        // minpos, never zero
        end else if (res.te == 1 - TE_MAX) begin
            // Exponent bit falls off here, neighbours are 2^-28 and 2^-26
            mag_sel = (res.mant[MANT_SUB_RESULT_SIZE-2 -: 2] != '0) ? (N-1)'(2) : (N-1)'(1);
        end else begin
            mag_sel = mag_rnd;
        end

        if (res.result_nar) begin
            word = NAR;
        end else if (res.result_zero) begin
            word = '0;
        end else begin
            word = res.sign ? posit_t'(-{1'b0, mag_sel}) : {1'b0, mag_sel};
        end
    end

    assign rsp.result = word;

    // NaR only comes from a NaR operand
    nar_only_in: assert final ($isunknown(res) || res.result_nar || word != NAR);

endmodule

// ==== rtl/posit_adder.sv ====
`timescale 1ns/1ps

module posit_adder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  posit_io_pkg::add_req_t in_req,
    output logic                   out_valid,
    input  logic                   out_ready,
    output posit_io_pkg::add_rsp_t out_rsp
);

    import posit_fmt_pkg::*;
    import posit_io_pkg::*;

    dec_pair_t    dec_pair;
    dec_pair_t    dec_pair_q;
    logic         dec_valid;
    logic         dec_ready;
    core_result_t core_res;
    add_rsp_t     enc_rsp;

    // ========================================================================
    // Stage 1: decode and register
    // ========================================================================

    posit_decode decode_inst (
        .req  (in_req),
        .pair (dec_pair)
    );

    pipe_stage #(
        .payload_t (dec_pair_t)
    ) dec_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (dec_pair),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec_pair_q)
    );

    // ========================================================================
    // Stage 2: add, round, register
    // ========================================================================

    core_add_sub core_inst (
        .pair (dec_pair_q),
        .res  (core_res)
    );

    posit_round_encode encode_inst (
        .res (core_res),
        .rsp (enc_rsp)
    );

    pipe_stage #(
        .payload_t (add_rsp_t)
    ) out_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (enc_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_rsp)
    );

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== dv/posit_adder_checker.sv ====
`timescale 1ns/1ps

module posit_adder_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   in_valid,
    input logic                   in_ready,
    input posit_io_pkg::add_req_t in_req,
    input logic                   out_valid,
    input logic                   out_ready,
    input posit_io_pkg::add_rsp_t out_rsp
);

    import posit_fmt_pkg::*;
    import posit_io_pkg::*;

    typedef logic signed [79:0] fix_t;          // Value times 2^40, exact for every posit<16,1>

    add_req_t req_q[$];
    longint   accept_q[$];
    longint   cycle          = 0;
    longint   last_stall     = -1;
    int       accepted_count = 0;
    int       result_count   = 0;
    int       mismatch_count = 0;
    int       protocol_count = 0;
    int       latency_count  = 0;

    // ========================================================================
    // Reference model
    // ========================================================================

    function automatic fix_t posit_value(input posit_t p);
        posit_t      m;
        int          i;
        int          k;
        int          e;
        int          nfrac;
        logic [79:0] sig;
        if (p == '0) begin
            return '0;
        end
        m = p[N-1] ? -p : p;
        i = N - 3;
        while (i >= 0 && m[i] == m[N-2]) begin
            i--;
        end
        k     = m[N-2] ? N - 3 - i : i - N + 2;  // Run ends at bit i
        e     = (i >= 1) ? m[i-1] : 0;
        nfrac = (i >= 1) ? i - 1 : 0;
        sig   = (80'(m) & ((80'd1 << nfrac) - 1)) | (80'd1 << nfrac);
        sig   = sig << (2 * k + e - nfrac + 40);  // ES = 1
        return p[N-1] ? -fix_t'(sig) : fix_t'(sig);
    endfunction

    // Exact a +- b, then nearest posit by value, ties to even
    function automatic posit_t expected_sum(input add_req_t req);
        fix_t   s;
        fix_t   mag;
        fix_t   d_lo;
        fix_t   d_hi;
        posit_t lo;
        posit_t hi;
        posit_t mid;
        posit_t p;
        if (req.a == NAR || req.b == NAR) begin
            return NAR;
        end
        s = req.sub ? posit_value(req.a) - posit_value(req.b)
                    : posit_value(req.a) + posit_value(req.b);
        if (s == 0) begin
            return '0;
        end
        mag = (s < 0) ? -s : s;
        lo  = 16'h0001;
        hi  = 16'h7fff;
        if (mag <= posit_value(lo)) begin
            p = lo;                              // Never rounds to zero
        end else if (mag >= posit_value(hi)) begin
            p = hi;
        end else begin
            while (hi - lo > 1) begin
                mid = (lo + hi) >> 1;
                if (posit_value(mid) <= mag) begin
                    lo = mid;
                end else begin
                    hi = mid;
                end
            end
            d_lo = mag - posit_value(lo);
            d_hi = posit_value(hi) - mag;
            if (d_lo == d_hi) begin
                p = lo[0] ? hi : lo;
            end else begin
                p = (d_lo < d_hi) ? lo : hi;
            end
        end
        return (s < 0) ? -p : p;
    endfunction

    // ========================================================================
    // Compare at each output transfer
    // ========================================================================

    always @(posedge clk) begin
        add_req_t req;
        posit_t   exp_word;
        longint   acc;
        if (!rst) begin
            if (!out_ready) begin
                last_stall = cycle;
            end
            // Two in flight fill both stages
            if (in_ready !== ((req_q.size() < 2) || out_ready)) begin
                protocol_count++;
                $display("protocol error at %0t: in_ready is %b with %0d requests in flight",
                         $time, in_ready, req_q.size());
            end
            if (out_valid && out_ready) begin
                if (req_q.size() == 0) begin
                    protocol_count++;
                    $display("protocol error at %0t: result %h with no request outstanding",
                             $time, out_rsp.result);
                end else begin
                    req      = req_q.pop_front();
                    acc      = accept_q.pop_front();
                    exp_word = expected_sum(req);
                    result_count++;
                    if (out_rsp.result !== exp_word) begin
                        mismatch_count++;
                        $display("mismatch at %0t: a=%h b=%h sub=%b got %h expected %h",
                                 $time, req.a, req.b, req.sub, out_rsp.result, exp_word);
                    end
                    if (last_stall < acc && cycle != acc + 2) begin
                        latency_count++;
                        $display("latency error at %0t: result took %0d cycles instead of 2",
                                 $time, cycle - acc);
                    end
                end
            end
            if (in_valid && in_ready) begin
                req_q.push_back(in_req);
                accept_q.push_back(cycle);
                accepted_count++;
            end
        end
        cycle = cycle + 1;
    end

endmodule

// ==== dv/posit_adder_tb.sv ====
`timescale 1ns/1ps

module posit_adder_tb;

    import posit_fmt_pkg::*;
    import posit_io_pkg::*;

    localparam real CLK_PERIOD_NS  = 4.0;
    localparam int  SEED           = 87561;
    localparam int  N_DIRECTED     = 40;
    localparam int  N_RANDOM       = 400;
    localparam int  N_TOTAL        = N_DIRECTED + 4 * N_RANDOM;  // Pairs may be sent twice
    localparam int  CYCLES_PER_REQ = 20;

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    add_req_t in_req;
    logic     out_valid;
    logic     out_ready;
    add_rsp_t out_rsp;
    logic     bp_on;
    logic     gaps_on;
    int       sent_count;
    int       count_errors;
    int       seed_ret;

    clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clk_inst (.clk(clk));

    posit_adder uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    posit_adder_checker chk (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    // ========================================================================
    // Stimulus helpers
    // ========================================================================

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    // Returns 0.5 ns after the accepting edge
    task automatic push_request(input posit_t a, input posit_t b, input logic sub);
        if (gaps_on && $urandom_range(3) == 0) begin
            idle_cycles($urandom_range(3, 1));
        end
        in_req.a = a;
        in_req.b = b;
        in_req.sub = sub;
        in_valid = 1'b1;
        sent_count++;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #0.5;
    endtask

    task automatic both_orders(input posit_t a, input posit_t b);
        push_request(a, b, 1'b0);
        push_request(b, a, 1'b0);
    endtask

    task automatic random_pair();
        posit_t a;
        posit_t b;
        logic   sub;
        a   = posit_t'($urandom);
        b   = posit_t'($urandom);
        sub = $urandom_range(1);
        case ($urandom_range(3))
            0: b[N-1] = a[N-1] ^ sub;                       // Same effective sign
            1: b = sub ? a ^ posit_t'($urandom_range(255))  // Near cancellation
                       : -(a ^ posit_t'($urandom_range(255)));
            default: ;
        endcase
        push_request(a, b, sub);
        if (!sub && $urandom_range(3) == 0) begin
            push_request(b, a, 1'b0);
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        seed_ret   = $urandom(SEED);
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_req     = '0;
        bp_on      = 1'b0;
        gaps_on    = 1'b0;
        sent_count = 0;
        repeat (10) @(posedge clk);
        #0.5;
        rst = 1'b0;

        push_request(16'h4000, 16'h4000, 1'b1);    // Exact cancellation
        push_request(16'h5a3c, 16'ha5c4, 1'b0);
        push_request(16'hc123, 16'hc123, 1'b1);
        both_orders(16'h0000, 16'h3c21);           // Zero operand
        both_orders(16'hb123, 16'h0000);
        push_request(16'h0000, 16'h0000, 1'b0);
        push_request(16'h0000, 16'h6100, 1'b1);
        both_orders(16'h8000, 16'h4000);           // NaR
        push_request(16'h4000, 16'h8000, 1'b1);
        push_request(16'h7fff, 16'h7fff, 1'b0);    // Beyond maxpos
        push_request(16'h8001, 16'h8001, 1'b0);
        push_request(16'h7fff, 16'h8001, 1'b1);
        push_request(16'h0002, 16'h0001, 1'b1);    // Near minpos
        both_orders(16'h4000, 16'h0003);           // Far below, sticky only
        push_request(16'h4000, 16'h0003, 1'b1);
        push_request(16'h4001, 16'h1000, 1'b0);
        push_request(16'h5fff, 16'h5fff, 1'b0);    // Carry into next regime
        both_orders(16'h6fff, 16'h0fff);
        push_request(16'h4001, 16'h4000, 1'b1);    // Heavy cancellation
        push_request(16'h4000, 16'hbfff, 1'b0);
        push_request(16'h2345, 16'h2344, 1'b1);

        repeat (N_RANDOM) random_pair();
        bp_on   = 1'b1;
        gaps_on = 1'b1;
        repeat (N_RANDOM) random_pair();
        in_valid = 1'b0;
        bp_on    = 1'b0;

        while (chk.result_count < chk.accepted_count) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        count_errors = (sent_count != chk.accepted_count)
                     + (chk.accepted_count != chk.result_count);
        if (count_errors != 0) begin
            $display("count error: %0d sent, %0d accepted, %0d results",
                     sent_count, chk.accepted_count, chk.result_count);
        end
        $display("errors: %0d mismatch, %0d protocol, %0d latency, %0d count",
                 chk.mismatch_count, chk.protocol_count, chk.latency_count, count_errors);
        if (chk.mismatch_count + chk.protocol_count + chk.latency_count + count_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Output back-pressure
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #0.5;
            out_ready = bp_on ? ($urandom_range(2) != 0) : 1'b1;
        end
    end

    initial begin
        #(CLK_PERIOD_NS * (CYCLES_PER_REQ * N_TOTAL + 20));
        $display("timeout: run did not finish within %0d request slots", N_TOTAL);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
rtl/posit_fmt_pkg.sv
rtl/posit_io_pkg.sv
rtl/pipe_stage.sv
rtl/posit_decode.sv
rtl/core_add.sv
rtl/core_sub.sv
rtl/core_add_sub.sv
rtl/posit_round_encode.sv
rtl/posit_adder.sv
dv/clk_gen.sv
dv/posit_adder_checker.sv
dv/posit_adder_tb.sv

// ==== Bender.yml ====
package:
  name: posit_adder

sources:
  - files:
      - rtl/posit_fmt_pkg.sv
      - rtl/posit_io_pkg.sv
      - rtl/pipe_stage.sv
      - rtl/posit_decode.sv
      - rtl/core_add.sv
      - rtl/core_sub.sv
      - rtl/core_add_sub.sv
      - rtl/posit_round_encode.sv
      - rtl/posit_adder.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/posit_adder_checker.sv
      - dv/posit_adder_tb.sv
